/* verilog/kinpira_bus_pkg.sv */
package kinpira_bus_pkg;

  // Host bus widths
  localparam int BWIDTH      = 32;
  localparam int WB_AWIDTH   = 12;
  localparam int REGION_BITS = 2;

  typedef logic [WB_AWIDTH-1:0] wb_addr_t;
  typedef logic [BWIDTH-1:0]    wb_data_t;

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat_w;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    wb_data_t dat_r;
  } wb_rsp_t;

  // Top address bits pick the region
  typedef enum logic [REGION_BITS-1:0] {
    REGION_REG    = 2'd0,
    REGION_IMG    = 2'd1,
    REGION_RENKON = 2'd2,
    REGION_GOBOU  = 2'd3
  } region_t;

  // Word offsets inside REGION_REG
  localparam int REG_WHICH      = 0;
  localparam int REG_REQ        = 1;
  localparam int REG_IN_OFFSET  = 2;
  localparam int REG_OUT_OFFSET = 3;
  localparam int REG_NET_OFFSET = 4;
  localparam int REG_TOTAL_OUT  = 5;
  localparam int REG_TOTAL_IN   = 6;
  localparam int REG_IMG_SIZE   = 7;
  localparam int REG_FIL_SIZE   = 8;
  localparam int REG_ACK        = 16;

endpackage

/* verilog/kinpira_cnn_pkg.sv */
package kinpira_cnn_pkg;

  localparam int DWIDTH  = 16;
  localparam int AWIDTH  = 32;
  localparam int IMGSIZE = 10;
  localparam int NETSIZE = 10;
  localparam int LWIDTH  = 10;
  localparam int QFRAC   = 8;

  typedef logic signed [DWIDTH-1:0] pixel_t;
  typedef logic signed [AWIDTH-1:0] acc_t;
  typedef logic [IMGSIZE-1:0]       img_addr_t;
  typedef logic [NETSIZE-1:0]       net_addr_t;
  typedef logic [LWIDTH-1:0]        len_t;

  typedef enum logic {
    WHICH_RENKON = 1'b0,
    WHICH_GOBOU  = 1'b1
  } which_t;

  typedef struct packed {
    img_addr_t in_offset;
    img_addr_t out_offset;
    net_addr_t net_offset;
    len_t      total_out;
    len_t      total_in;
    len_t      img_size;
    len_t      fil_size;
  } layer_t;

  // Host write into one of the memories
  typedef struct packed {
    logic      we;
    img_addr_t addr;
    pixel_t    wdata;
  } mem_wr_t;

  // Engine side of the image buffer
  typedef struct packed {
    logic      we;
    img_addr_t addr;
    pixel_t    wdata;
  } img_port_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_DRAIN,
    ST_WRITE
  } engine_state_t;

  // Arithmetic shift by the fraction bits, low word kept
  function automatic pixel_t fixed_result(acc_t acc);
    acc_t shifted;
    shifted = acc >>> QFRAC;
    return shifted[DWIDTH-1:0];
  endfunction

endpackage

/* verilog/kinpira_wb_slave.sv */
`timescale 1ns/1ps

module kinpira_wb_slave
  import kinpira_bus_pkg::*, kinpira_cnn_pkg::*;
(
  input  logic    clk,
  input  logic    xrst,
  input  wb_req_t wb_in,
  output wb_rsp_t wb_out,
  output layer_t  layer,
  output which_t  which,
  output logic    start,
  input  logic    done,
  output mem_wr_t img_wr,
  output mem_wr_t renkon_wr,
  output mem_wr_t gobou_wr,
  input  pixel_t  img_rdata,
  input  pixel_t  renkon_rdata,
  input  pixel_t  gobou_rdata
);

  localparam int OFS_W = WB_AWIDTH - REGION_BITS;

  logic             ack_q;
  logic             start_q;
  logic             req_cycle;
  logic             wr_cycle;
  region_t          region;
  region_t          region_q;
  logic [OFS_W-1:0] ofs;
  logic [OFS_W-1:0] ofs_q;
  wb_data_t         reg_rdata;

  // New request only when no ack is pending
  assign req_cycle = wb_in.cyc && wb_in.stb && !ack_q;
  assign wr_cycle  = req_cycle && wb_in.we;
  assign region    = region_t'(wb_in.adr[WB_AWIDTH-1 -: REGION_BITS]);
  assign ofs       = wb_in.adr[OFS_W-1:0];

  // Memories see the bus address every cycle for synchronous reads
  assign img_wr.we       = wr_cycle && region == REGION_IMG;
  assign img_wr.addr     = ofs[IMGSIZE-1:0];
  assign img_wr.wdata    = wb_in.dat_w[DWIDTH-1:0];
  assign renkon_wr.we    = wr_cycle && region == REGION_RENKON;
  assign renkon_wr.addr  = ofs[IMGSIZE-1:0];
  assign renkon_wr.wdata = wb_in.dat_w[DWIDTH-1:0];
  assign gobou_wr.we     = wr_cycle && region == REGION_GOBOU;
  assign gobou_wr.addr   = ofs[IMGSIZE-1:0];
  assign gobou_wr.wdata  = wb_in.dat_w[DWIDTH-1:0];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      ack_q    <= 1'b0;
      start_q  <= 1'b0;
      region_q <= REGION_REG;
      ofs_q    <= '0;
      which    <= WHICH_RENKON;
      layer    <= '0;
    end else begin
      ack_q   <= req_cycle;
      // Request is dropped while the engine is busy
      start_q <= wr_cycle && region == REGION_REG && ofs == OFS_W'(REG_REQ)
                 && wb_in.dat_w[0] && done;
      if (req_cycle) begin
        region_q <= region;
        ofs_q    <= ofs;
      end
      if (wr_cycle && region == REGION_REG) begin
        case (ofs)
          REG_WHICH:      which            <= which_t'(wb_in.dat_w[0]);
          REG_IN_OFFSET:  layer.in_offset  <= wb_in.dat_w[IMGSIZE-1:0];
          REG_OUT_OFFSET: layer.out_offset <= wb_in.dat_w[IMGSIZE-1:0];
          REG_NET_OFFSET: layer.net_offset <= wb_in.dat_w[NETSIZE-1:0];
          REG_TOTAL_OUT:  layer.total_out  <= wb_in.dat_w[LWIDTH-1:0];
          REG_TOTAL_IN:   layer.total_in   <= wb_in.dat_w[LWIDTH-1:0];
          REG_IMG_SIZE:   layer.img_size   <= wb_in.dat_w[LWIDTH-1:0];
          REG_FIL_SIZE:   layer.fil_size   <= wb_in.dat_w[LWIDTH-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (ofs_q)
      REG_WHICH:      reg_rdata = wb_data_t'(which);
      REG_IN_OFFSET:  reg_rdata = wb_data_t'(layer.in_offset);
      REG_OUT_OFFSET: reg_rdata = wb_data_t'(layer.out_offset);
      REG_NET_OFFSET: reg_rdata = wb_data_t'(layer.net_offset);
      REG_TOTAL_OUT:  reg_rdata = wb_data_t'(layer.total_out);
      REG_TOTAL_IN:   reg_rdata = wb_data_t'(layer.total_in);
      REG_IMG_SIZE:   reg_rdata = wb_data_t'(layer.img_size);
      REG_FIL_SIZE:   reg_rdata = wb_data_t'(layer.fil_size);
      REG_ACK:        reg_rdata = wb_data_t'(done);
      default:        reg_rdata = '0;
    endcase
  end

  // Memory words come back sign extended
  always_comb begin
    case (region_q)
      REGION_IMG:    wb_out.dat_r = wb_data_t'(img_rdata);
      REGION_RENKON: wb_out.dat_r = wb_data_t'(renkon_rdata);
      REGION_GOBOU:  wb_out.dat_r = wb_data_t'(gobou_rdata);
      default:       wb_out.dat_r = reg_rdata;
    endcase
  end

  assign wb_out.ack = ack_q;
  assign start      = start_q;

endmodule

/* verilog/kinpira_img_buf.sv */
`timescale 1ns/1ps

module kinpira_img_buf
  import kinpira_cnn_pkg::*;
#(
  parameter int ADDR_W = IMGSIZE
)
(
  input  logic      clk,
  input  mem_wr_t   host_wr,
  output pixel_t    host_rdata,
  input  img_port_t eng,
  output pixel_t    eng_rdata
);

  pixel_t mem [2**ADDR_W];

  // Host port
  always @(posedge clk) begin
    if (host_wr.we) begin
      mem[host_wr.addr[ADDR_W-1:0]] <= host_wr.wdata;
    end
    host_rdata <= mem[host_wr.addr[ADDR_W-1:0]];
  end

  // Engine port
  always @(posedge clk) begin
    if (eng.we) begin
      mem[eng.addr[ADDR_W-1:0]] <= eng.wdata;
    end
    eng_rdata <= mem[eng.addr[ADDR_W-1:0]];
  end

endmodule

/* verilog/renkon_conv.sv */
`timescale 1ns/1ps

module renkon_conv
  import kinpira_cnn_pkg::*;
#(
  parameter int ADDR_W = NETSIZE
)
(
  input  logic      clk,
  input  logic      xrst,
  input  logic      start,
  input  layer_t    layer,
  input  mem_wr_t   net_wr,
  output pixel_t    net_rdata,
  output img_port_t img,
  input  pixel_t    img_rdata,
  output logic      done
);

  pixel_t        net_mem [2**ADDR_W];
  net_addr_t     net_raddr;
  pixel_t        w_rdata;
  engine_state_t state;
  len_t          j;
  len_t          k;
  logic          last_k;
  logic          last_j;
  logic          rd_valid;
  acc_t          prod;
  acc_t          acc;

  // Weight memory, host port plus engine read port
  always_ff @(posedge clk) begin
    if (net_wr.we) begin
      net_mem[net_wr.addr[ADDR_W-1:0]] <= net_wr.wdata;
    end
    net_rdata <= net_mem[net_wr.addr[ADDR_W-1:0]];
    w_rdata   <= net_mem[net_raddr[ADDR_W-1:0]];
  end

  assign net_raddr = layer.net_offset + k;
  assign last_k    = k == len_t'(layer.fil_size - 1'b1);
  // Valid outputs run up to img_size - fil_size
  assign last_j    = j == len_t'(layer.img_size - layer.fil_size);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state    <= ST_IDLE;
      j        <= '0;
      k        <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= state == ST_FETCH;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_FETCH;
            j     <= '0;
            k     <= '0;
          end
        end
        ST_FETCH: begin
          k <= k + 1'b1;
          if (last_k) begin
            state <= ST_DRAIN;
          end
        end
        ST_DRAIN: state <= ST_WRITE;
        ST_WRITE: begin
          k     <= '0;
          j     <= j + 1'b1;
          state <= last_j ? ST_IDLE : ST_FETCH;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign prod = acc_t'(img_rdata) * acc_t'(w_rdata);

  // Data of the previous fetch arrives now
  always_ff @(posedge clk) begin
    if (state == ST_IDLE || state == ST_WRITE) begin
      acc <= '0;
    end else if (rd_valid) begin
      acc <= acc + prod;
    end
  end

  always_comb begin
    img.we    = state == ST_WRITE;
    img.wdata = fixed_result(acc);
    if (state == ST_WRITE) begin
      img.addr = layer.out_offset + j;
    end else begin
      img.addr = layer.in_offset + j + k;
    end
  end

  assign done = state == ST_IDLE;

endmodule

/* verilog/gobou_fc.sv */
`timescale 1ns/1ps

module gobou_fc
  import kinpira_cnn_pkg::*;
#(
  parameter int ADDR_W = NETSIZE
)
(
  input  logic      clk,
  input  logic      xrst,
  input  logic      start,
  input  layer_t    layer,
  input  mem_wr_t   net_wr,
  output pixel_t    net_rdata,
  output img_port_t img,
  input  pixel_t    img_rdata,
  output logic      done
);

  pixel_t        net_mem [2**ADDR_W];
  net_addr_t     net_ptr;
  pixel_t        w_rdata;
  engine_state_t state;
  len_t          o;
  len_t          i;
  logic          last_i;
  logic          last_o;
  logic          rd_valid;
  acc_t          prod;
  acc_t          acc;

  always_ff @(posedge clk) begin
    if (net_wr.we) begin
      net_mem[net_wr.addr[ADDR_W-1:0]] <= net_wr.wdata;
    end
    net_rdata <= net_mem[net_wr.addr[ADDR_W-1:0]];
    w_rdata   <= net_mem[net_ptr[ADDR_W-1:0]];
  end

  assign last_i = i == len_t'(layer.total_in - 1'b1);
  assign last_o = o == len_t'(layer.total_out - 1'b1);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state    <= ST_IDLE;
      o        <= '0;
      i        <= '0;
      net_ptr  <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= state == ST_FETCH;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state   <= ST_FETCH;
            o       <= '0;
            i       <= '0;
            net_ptr <= layer.net_offset;
          end
        end
        ST_FETCH: begin
          // Weight rows are contiguous, so the pointer never rewinds
          i       <= i + 1'b1;
          net_ptr <= net_ptr + 1'b1;
          if (last_i) begin
            state <= ST_DRAIN;
          end
        end
        ST_DRAIN: state <= ST_WRITE;
        ST_WRITE: begin
          i     <= '0;
          o     <= o + 1'b1;
          state <= last_o ? ST_IDLE : ST_FETCH;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign prod = acc_t'(img_rdata) * acc_t'(w_rdata);

  always_ff @(posedge clk) begin
    if (state == ST_IDLE || state == ST_WRITE) begin
      acc <= '0;
    end else if (rd_valid) begin
      acc <= acc + prod;
    end
  end

  always_comb begin
    img.we    = state == ST_WRITE;
    img.wdata = fixed_result(acc);
    if (state == ST_WRITE) begin
      img.addr = layer.out_offset + o;
    end else begin
      img.addr = layer.in_offset + i;
    end
  end

  assign done = state == ST_IDLE;

endmodule

/* verilog/kinpira_top.sv */
`timescale 1ns/1ps

module kinpira_top
  import kinpira_bus_pkg::*, kinpira_cnn_pkg::*;
(
  input  logic    clk,
  input  logic    xrst,
  input  wb_req_t wb_in,
  output wb_rsp_t wb_out
);

  layer_t    layer;
  which_t    which;
  logic      start;
  logic      done;
  mem_wr_t   img_wr;
  mem_wr_t   renkon_wr;
  mem_wr_t   gobou_wr;
  pixel_t    img_rdata;
  pixel_t    renkon_rdata;
  pixel_t    gobou_rdata;
  pixel_t    eng_rdata;
  img_port_t eng_port;
  img_port_t renkon_img;
  img_port_t gobou_img;
  logic      renkon_start;
  logic      gobou_start;
  logic      renkon_done;
  logic      gobou_done;

  kinpira_wb_slave u_slave (
    .clk          (clk),
    .xrst         (xrst),
    .wb_in        (wb_in),
    .wb_out       (wb_out),
    .layer        (layer),
    .which        (which),
    .start        (start),
    .done         (done),
    .img_wr       (img_wr),
    .renkon_wr    (renkon_wr),
    .gobou_wr     (gobou_wr),
    .img_rdata    (img_rdata),
    .renkon_rdata (renkon_rdata),
    .gobou_rdata  (gobou_rdata)
  );

  // Engine selection
  assign renkon_start = start && which == WHICH_RENKON;
  assign gobou_start  = start && which == WHICH_GOBOU;
  assign eng_port     = (which == WHICH_GOBOU) ? gobou_img : renkon_img;
  assign done         = (which == WHICH_GOBOU) ? gobou_done : renkon_done;

  kinpira_img_buf u_img_buf (
    .clk        (clk),
    .host_wr    (img_wr),
    .host_rdata (img_rdata),
    .eng        (eng_port),
    .eng_rdata  (eng_rdata)
  );

  renkon_conv u_renkon (
    .clk       (clk),
    .xrst      (xrst),
    .start     (renkon_start),
    .layer     (layer),
    .net_wr    (renkon_wr),
    .net_rdata (renkon_rdata),
    .img       (renkon_img),
    .img_rdata (eng_rdata),
    .done      (renkon_done)
  );

  gobou_fc u_gobou (
    .clk       (clk),
    .xrst      (xrst),
    .start     (gobou_start),
    .layer     (layer),
    .net_wr    (gobou_wr),
    .net_rdata (gobou_rdata),
    .img       (gobou_img),
    .img_rdata (eng_rdata),
    .done      (gobou_done)
  );

endmodule

/* dv/kinpira_monitor.sv */
`timescale 1ns/1ps

module kinpira_monitor
  import kinpira_bus_pkg::*, kinpira_cnn_pkg::*;
(
  input  logic    clk,
  input  logic    xrst,
  input  wb_req_t wb_in,
  input  wb_rsp_t wb_out,
  output int      errors,
  output int      reads
);

  logic [15:0] img [1024];
  // Weight shadows, index 0 for renkon and 1 for gobou
  logic [15:0] net [2][1024];
  int          regs [9];
  // Cycles until the done flag is back, zero when idle
  int          remain;

  function automatic longint word(logic [15:0] w);
    return longint'($signed(w));
  endfunction

  // Outputs are written in order, as the engines do
  task automatic run_engine(output int cycles);
    int     gobou;
    int     nout;
    int     nterm;
    int     o;
    int     t;
    int     ia;
    int     wa;
    longint acc;
    gobou = regs[REG_WHICH];
    nout  = gobou ? regs[REG_TOTAL_OUT] : regs[REG_IMG_SIZE] - regs[REG_FIL_SIZE] + 1;
    nterm = gobou ? regs[REG_TOTAL_IN] : regs[REG_FIL_SIZE];
    for (o = 0; o < nout; o++) begin
      acc = 0;
      for (t = 0; t < nterm; t++) begin
        ia  = (regs[REG_IN_OFFSET] + (gobou ? t : o + t)) % 1024;
        wa  = (regs[REG_NET_OFFSET] + (gobou ? o * nterm : 0) + t) % 1024;
        acc = acc + word(img[ia]) * word(net[gobou][wa]);
      end
      acc = acc >>> QFRAC;
      img[(regs[REG_OUT_OFFSET] + o) % 1024] = acc[15:0];
    end
    // One cycle per term plus drain and write for each output
    cycles = nout * (nterm + 2);
  endtask

  always @(posedge clk) begin
    logic [1:0]  region;
    int          ofs;
    int          run_len;
    logic        idle;
    logic [31:0] exp;
    region = wb_in.adr[WB_AWIDTH-1 -: REGION_BITS];
    ofs    = int'(wb_in.adr[WB_AWIDTH-REGION_BITS-1:0]);
    if (!xrst) begin
      regs   = '{default: 0};
      remain = 0;
      errors = 0;
      reads  = 0;
    end else begin
      // Done as the slave saw it in the request cycle
      idle = remain == 0;
      if (remain > 0) begin
        remain--;
      end
      if (wb_in.cyc && wb_in.stb && wb_out.ack) begin
        if (wb_in.we) begin
          case (region)
            REGION_IMG:    img[ofs] = wb_in.dat_w[15:0];
            REGION_RENKON: net[0][ofs] = wb_in.dat_w[15:0];
            REGION_GOBOU:  net[1][ofs] = wb_in.dat_w[15:0];
            default: begin
              if (ofs == REG_REQ && wb_in.dat_w[0] && idle) begin
                run_engine(run_len);
                // Done drops after the start pulse and rises after the last write
                remain = run_len + 1;
              end else if (ofs == REG_WHICH) begin
                regs[ofs] = int'(wb_in.dat_w[0]);
              end else if (ofs <= REG_FIL_SIZE && ofs != REG_REQ) begin
                regs[ofs] = int'(wb_in.dat_w[9:0]);
              end
            end
          endcase
        end else begin
          reads++;
          case (region)
            REGION_IMG:    exp = {{16{img[ofs][15]}}, img[ofs]};
            REGION_RENKON: exp = {{16{net[0][ofs][15]}}, net[0][ofs]};
            REGION_GOBOU:  exp = {{16{net[1][ofs][15]}}, net[1][ofs]};
            default: begin
              exp = (ofs <= REG_FIL_SIZE) ? regs[ofs]
                                          : 32'(ofs == REG_ACK && remain == 0);
            end
          endcase
          if (wb_out.dat_r !== exp) begin
            errors++;
            $display("FAIL wb_out.dat_r adr %h: got %h, expected %h",
                     wb_in.adr, wb_out.dat_r, exp);
          end
        end
      end
    end
  end

endmodule

/* dv/kinpira_chk.sv */
`timescale 1ns/1ps

module kinpira_chk
  import kinpira_bus_pkg::*, kinpira_cnn_pkg::*;
(
  input logic      clk,
  input logic      xrst,
  input wb_req_t   wb_in,
  input wb_rsp_t   wb_out,
  input logic      done,
  input img_port_t eng_port
);

  int fail_count = 0;

  ack_after_req: assert property (@(posedge clk) disable iff (!xrst)
    wb_out.ack |-> $past(wb_in.cyc && wb_in.stb))
    else begin
      fail_count++;
      $error("wb ack raised without cyc and stb in the cycle before");
    end

  ack_one_cycle: assert property (@(posedge clk) disable iff (!xrst)
    wb_out.ack |=> !wb_out.ack)
    else begin
      fail_count++;
      $error("wb ack stayed high for two cycles");
    end

  // Only a running engine writes the image buffer
  no_write_when_done: assert property (@(posedge clk) disable iff (!xrst)
    done |-> !eng_port.we)
    else begin
      fail_count++;
      $error("engine image port wrote while the done flag was high");
    end

  done_after_reset: assert property (@(posedge clk)
    $rose(xrst) |-> done)
    else begin
      fail_count++;
      $error("done flag low on the first cycle after reset");
    end

endmodule

bind kinpira_top kinpira_chk u_chk (
  .clk      (clk),
  .xrst     (xrst),
  .wb_in    (wb_in),
  .wb_out   (wb_out),
  .done     (done),
  .eng_port (eng_port)
);

/* dv/kinpira_tb.sv */
`timescale 1ns/1ps

module kinpira_tb
  import kinpira_bus_pkg::*;
();

  localparam int PERIOD = 10;
  localparam int NROWS  = 5;
  localparam int OFS_W  = WB_AWIDTH - REGION_BITS;

  typedef struct packed {
    int which;
    int in_off;
    int out_off;
    int net_off;
    int total_out;
    int total_in;
    int img_size;
    int fil_size;
  } row_t;

  // which, in_off, out_off, net_off, total_out, total_in, img_size, fil_size
  localparam row_t ROWS [NROWS] = '{
    '{1, 0,    100, 0,    1, 1, 0,  0},
    '{1, 10,   120, 16,   4, 6, 0,  0},
    '{0, 200,  300, 40,   0, 0, 12, 3},
    '{0, 400,  450, 60,   0, 0, 5,  5},
    '{1, 1020, 500, 1000, 3, 8, 0,  0}
  };

  logic    clk;
  logic    xrst;
  wb_req_t wb_in;
  wb_rsp_t wb_out;
  int      mon_errors;
  int      mon_reads;

  kinpira_top DUT (
    .clk    (clk),
    .xrst   (xrst),
    .wb_in  (wb_in),
    .wb_out (wb_out)
  );

  kinpira_monitor u_mon (
    .clk    (clk),
    .xrst   (xrst),
    .wb_in  (wb_in),
    .wb_out (wb_out),
    .errors (mon_errors),
    .reads  (mon_reads)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  function automatic int n_inputs(row_t r);
    return r.which ? r.total_in : r.img_size;
  endfunction

  function automatic int n_outputs(row_t r);
    return r.which ? r.total_out : r.img_size - r.fil_size + 1;
  endfunction

  function automatic int n_weights(row_t r);
    return r.which ? r.total_out * r.total_in : r.fil_size;
  endfunction

  function automatic int budget_cycles();
    int cycles;
    int n;
    cycles = 200;
    for (n = 0; n < NROWS; n++) begin
      cycles += 4 * n_outputs(ROWS[n]) * (ROWS[n].which ? ROWS[n].total_in : ROWS[n].fil_size);
      cycles += 4 * (n_inputs(ROWS[n]) + n_outputs(ROWS[n]) + n_weights(ROWS[n]) + 16);
    end
    return cycles;
  endfunction

  function automatic wb_data_t small_rand();
    int v;
    v = int'($urandom_range(127)) - 64;
    return wb_data_t'(v);
  endfunction

  // Called on a falling edge, returns on a falling edge
  task automatic bus_xfer(input logic we, input int region, input int ofs,
                          input wb_data_t wdata, output wb_data_t rdata);
    wb_in.cyc   = 1'b1;
    wb_in.stb   = 1'b1;
    wb_in.we    = we;
    wb_in.adr   = wb_addr_t'((region << OFS_W) | (ofs & ((1 << OFS_W) - 1)));
    wb_in.dat_w = wdata;
    @(negedge clk);
    while (wb_out.ack !== 1'b1) begin
      @(negedge clk);
    end
    rdata = wb_out.dat_r;
    // Hold the request through the ack edge
    @(negedge clk);
    wb_in = '0;
  endtask

  task automatic bus_write(input int region, input int ofs, input wb_data_t data);
    wb_data_t unused;
    bus_xfer(1'b1, region, ofs, data, unused);
  endtask

  task automatic bus_read(input int region, input int ofs, output wb_data_t data);
    bus_xfer(1'b0, region, ofs, '0, data);
  endtask

  task automatic run_row(input row_t r);
    wb_data_t rd;
    int       wreg;
    int       i;
    wreg = r.which ? REGION_GOBOU : REGION_RENKON;
    for (i = 0; i < n_inputs(r); i++) bus_write(REGION_IMG, r.in_off + i, small_rand());
    // Output range plus one guard word on each side
    for (i = -1; i <= n_outputs(r); i++) bus_write(REGION_IMG, r.out_off + i, small_rand());
    for (i = 0; i < n_weights(r); i++) bus_write(wreg, r.net_off + i, small_rand());
    for (i = 0; i < n_weights(r); i++) bus_read(wreg, r.net_off + i, rd);
    bus_write(REGION_REG, REG_WHICH, r.which);
    bus_write(REGION_REG, REG_IN_OFFSET, r.in_off);
    bus_write(REGION_REG, REG_OUT_OFFSET, r.out_off);
    bus_write(REGION_REG, REG_NET_OFFSET, r.net_off);
    bus_write(REGION_REG, REG_TOTAL_OUT, r.total_out);
    bus_write(REGION_REG, REG_TOTAL_IN, r.total_in);
    bus_write(REGION_REG, REG_IMG_SIZE, r.img_size);
    bus_write(REGION_REG, REG_FIL_SIZE, r.fil_size);
    for (i = 0; i <= REG_FIL_SIZE; i++) bus_read(REGION_REG, i, rd);
    bus_write(REGION_REG, REG_REQ, 32'd1);
    // Engine already busy here
    bus_write(REGION_REG, REG_REQ, 32'd1);
    do begin
      bus_read(REGION_REG, REG_ACK, rd);
    end while (rd !== 32'd1);
    for (i = -1; i <= n_outputs(r); i++) bus_read(REGION_IMG, r.out_off + i, rd);
    for (i = 0; i < n_inputs(r); i++) bus_read(REGION_IMG, r.in_off + i, rd);
  endtask

  initial begin
    wb_data_t rd;
    int       i;
    int       total;
    wb_in = '0;
    xrst  = 1'b0;
    void'($urandom(32'hac5));
    repeat (3) @(posedge clk);
    @(negedge clk);
    xrst = 1'b1;
    for (i = 0; i <= REG_FIL_SIZE; i++) bus_read(REGION_REG, i, rd);
    bus_read(REGION_REG, REG_ACK, rd);
    // Top word of each memory, upper data bits dropped
    for (i = REGION_IMG; i <= REGION_GOBOU; i++) begin
      bus_write(i, 1023, 32'hdead_8001 + i);
      bus_read(i, 1023, rd);
    end
    for (i = 0; i < NROWS; i++) run_row(ROWS[i]);
    total = mon_errors + DUT.u_chk.fail_count;
    $display("Run complete: %0d reads checked, %0d errors", mon_reads, total);
    if (total == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(budget_cycles() * PERIOD);
    $display("Watchdog expired after %0d cycles", budget_cycles());
    $display("Errors found");
    $finish;
  end

endmodule

/* kinpira.f */
verilog/kinpira_bus_pkg.sv
verilog/kinpira_cnn_pkg.sv
verilog/kinpira_wb_slave.sv
verilog/kinpira_img_buf.sv
verilog/renkon_conv.sv
verilog/gobou_fc.sv
verilog/kinpira_top.sv
dv/kinpira_monitor.sv
dv/kinpira_chk.sv
dv/kinpira_tb.sv

/* Bender.yml */
package:
  name: kinpira

sources:
  - verilog/kinpira_bus_pkg.sv
  - verilog/kinpira_cnn_pkg.sv
  - verilog/kinpira_wb_slave.sv
  - verilog/kinpira_img_buf.sv
  - verilog/renkon_conv.sv
  - verilog/gobou_fc.sv
  - verilog/kinpira_top.sv
  - target: test
    files:
      - dv/kinpira_monitor.sv
      - dv/kinpira_chk.sv
      - dv/kinpira_tb.sv
